//--- Bender.yml
package:
  name: mmio_subsys

sources:
  - include_dirs:
      - .
    files:
      - mmio_pkg.sv
      - clint_timer.sv
      - bus_arbiter.sv
      - dcache_store.sv
      - uncache_mmio.sv
      - mmio_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mmio_subsys.sv

//--- bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  mmio_pkg::wb_req_t m0_req,   // Uncached device path.
    input  mmio_pkg::wb_req_t m1_req,   // Cache refills and stores.
    output mmio_pkg::wb_rsp_t m0_rsp,
    output mmio_pkg::wb_rsp_t m1_rsp,
    output mmio_pkg::wb_req_t wb_out,
    input  mmio_pkg::wb_rsp_t wb_in
);

    logic [1:0] gnt_q;   // One-hot grant. Zero while the bus is idle.
    logic       release_gnt;

    // The owner has dropped its cycle.
    assign release_gnt = (gnt_q[0] && !m0_req.cyc) || (gnt_q[1] && !m1_req.cyc);

    // ######################################################################
    // Grant register.
    // ######################################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            gnt_q <= 2'b00;
        end else if (gnt_q == 2'b00) begin
            if (m0_req.cyc)      gnt_q <= 2'b01;   // Port 0 has priority.
            else if (m1_req.cyc) gnt_q <= 2'b10;
        end else if (release_gnt) begin
            gnt_q <= 2'b00;                        // Back to idle for one cycle.
        end
    end

    // Granted master drives the bus.
    always_comb begin
        if (gnt_q[0])      wb_out = m0_req;
        else if (gnt_q[1]) wb_out = m1_req;
        else               wb_out = '0;
    end

    // Replies go to the owner only.
    assign m0_rsp.ack   = gnt_q[0] && wb_in.ack;
    assign m0_rsp.dat_r = gnt_q[0] ? wb_in.dat_r : 64'd0;
    assign m1_rsp.ack   = gnt_q[1] && wb_in.ack;
    assign m1_rsp.dat_r = gnt_q[1] ? wb_in.dat_r : 64'd0;

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0(gnt_q));

endmodule

//--- clint_timer.sv
`timescale 1ns/1ns
`include "mmio_config.svh"

module clint_timer (
    input  logic                clk,
    input  logic                rst,
    input  mmio_pkg::core_req_t req,
    output mmio_pkg::core_rsp_t rsp,
    output logic                timer_irq
);

    mmio_pkg::addr_view_u av;
    logic [63:0]          mtime_q;
    logic [63:0]          mtimecmp_q;
    logic [63:0]          wmask;       // Byte lanes widened to bits.
    logic                 hit_cmp, hit_time;
    logic                 init_q;      // First cycle after reset.
    logic                 irq_q;
    logic                 fin_q;
    logic [63:0]          rdata_q;

    assign av       = req.addr;
    assign hit_cmp  = (av.dev.reg_off == `MMIO_CLINT_MTIMECMP);
    assign hit_time = (av.dev.reg_off == `MMIO_CLINT_MTIME);

    always_comb begin
        for (int b = 0; b < 8; b++) begin
            wmask[8*b +: 8] = {8{req.mask[b]}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q    <= 64'd0;
            mtimecmp_q <= 64'd0;
            init_q     <= 1'b1;
            irq_q      <= 1'b0;
            fin_q      <= 1'b0;
        end else begin
            init_q <= 1'b0;
            fin_q  <= req.we || req.re;                        // One-cycle answer.
            if (req.we && hit_time) mtime_q <= (mtime_q & ~wmask) | (req.wdata & wmask);
            else                    mtime_q <= mtime_q + 64'd1;  // Free running.
            if (init_q) begin
                mtimecmp_q <= '1;                              // Nothing pending.
            end else if (req.we && hit_cmp) begin
                mtimecmp_q <= (mtimecmp_q & ~wmask) | (req.wdata & wmask);
            end
            irq_q <= !init_q && (mtime_q >= mtimecmp_q);
        end
    end

    // Read data. Unknown offsets read zero.
    always_ff @(posedge clk) begin
        if (req.re) rdata_q <= hit_cmp ? mtimecmp_q : (hit_time ? mtime_q : 64'd0);
    end

    assign rsp.rdata  = rdata_q;
    assign rsp.finish = fin_q;
    assign timer_irq  = irq_q;

endmodule

//--- dcache_store.sv
`timescale 1ns/1ns
`include "mmio_config.svh"

module dcache_store (
    input  logic                clk,
    input  logic                rst,
    input  mmio_pkg::core_req_t req,
    input  logic                fence,
    output mmio_pkg::core_rsp_t rsp,
    output mmio_pkg::wb_req_t   bus_req,
    input  mmio_pkg::wb_rsp_t   bus_rsp
);

    localparam int LINES = `MMIO_DCACHE_LINES;

    typedef enum logic [1:0] {S_IDLE, S_REFILL, S_WRITE} state_t;

    state_t                        state_q;
    mmio_pkg::core_req_t           req_q;            // Request under service.
    mmio_pkg::addr_view_u          av_in, av_q;
    logic [mmio_pkg::DC_TAG_W-1:0] tag_q  [LINES];
    logic [63:0]                   data_q [LINES];
    logic [LINES-1:0]              valid_q;
    logic                          hit_in, hit_q;
    logic                          fill_we, merge_we;
    logic [63:0]                   merged;
    logic [63:0]                   rdata_q;
    logic                          fin_q;

    assign av_in = req.addr;
    assign av_q  = req_q.addr;

    // Tag compare for a new request and for the one in flight.
    assign hit_in = valid_q[av_in.cache.index] && (tag_q[av_in.cache.index] == av_in.cache.tag);
    assign hit_q  = valid_q[av_q.cache.index] && (tag_q[av_q.cache.index] == av_q.cache.tag);

    assign fill_we  = (state_q == S_REFILL) && bus_rsp.ack;
    assign merge_we = (state_q == S_WRITE) && bus_rsp.ack && hit_q;   // Write hits only.

    // Byte merge of the store into the cached word.
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            merged[8*b +: 8] = req_q.mask[b] ? req_q.wdata[8*b +: 8]
                                             : data_q[av_q.cache.index][8*b +: 8];
        end
    end

    // ######################################################################
    // Control.
    // ######################################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            valid_q <= '0;
            fin_q   <= 1'b0;
        end else begin
            fin_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (req.re && hit_in) fin_q <= 1'b1;       // Answer from the array.
                    else if (req.re)      state_q <= S_REFILL;
                    else if (req.we)      state_q <= S_WRITE;  // Write-through.
                end
                S_REFILL: if (bus_rsp.ack) begin
                    valid_q[av_q.cache.index] <= 1'b1;
                    fin_q   <= 1'b1;
                    state_q <= S_IDLE;
                end
                S_WRITE: if (bus_rsp.ack) begin
                    fin_q   <= 1'b1;
                    state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
            if (fence) valid_q <= '0;                          // Invalidate all lines.
        end
    end

    // Array and capture registers.
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && (req.re || req.we)) req_q <= req;
        if (state_q == S_IDLE && req.re && hit_in) rdata_q <= data_q[av_in.cache.index];
        if (fill_we) begin
            data_q[av_q.cache.index] <= bus_rsp.dat_r;
            tag_q[av_q.cache.index]  <= av_q.cache.tag;
            rdata_q                  <= bus_rsp.dat_r;        // Forward the refill word.
        end
        if (merge_we) data_q[av_q.cache.index] <= merged;
    end

    assign rsp.rdata  = rdata_q;
    assign rsp.finish = fin_q;

    // Bus side on arbiter port 1. Whole aligned word.
    assign bus_req.adr   = {av_q.cache.tag, av_q.cache.index, 3'b000};
    assign bus_req.dat_w = req_q.wdata;
    assign bus_req.sel   = (state_q == S_WRITE) ? req_q.mask : 8'hFF;
    assign bus_req.we    = (state_q == S_WRITE);
    assign bus_req.cyc   = (state_q != S_IDLE);
    assign bus_req.stb   = (state_q != S_IDLE);

    // A refill fill comes from a bus read and answers the core next cycle.
    a_refill_fill: assert property (@(posedge clk) disable iff (rst)
        fill_we |-> (bus_req.cyc && !bus_req.we) ##1 rsp.finish);

endmodule

//--- mmio_config.svh
`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

// ##########################################################################
// Address map of the memory access path.
// ##########################################################################
`define MMIO_CLINT_START        64'h0000_0000_0200_0000 // Core local interruptor.
`define MMIO_CLINT_END          64'h0000_0000_0200_FFFF
`define MMIO_UART_START         64'h0000_0000_1000_0000 // UART registers.
`define MMIO_UART_END           64'h0000_0000_1000_0FFF
`define MMIO_SPICTRL_START      64'h0000_0000_1000_1000 // SPI controller registers.
`define MMIO_SPICTRL_END        64'h0000_0000_1000_1FFF
`define MMIO_SPI_START          64'h0000_0000_3000_0000 // SPI flash, mapped read window.
`define MMIO_SPI_END            64'h0000_0000_3FFF_FFFF

// CLINT register offsets inside the window.
`define MMIO_CLINT_MTIMECMP     16'h4000
`define MMIO_CLINT_MTIME        16'hBFF8

// Direct-mapped, one 64-bit word per line.
`define MMIO_DCACHE_LINES       8

// Access size codes, bytes = 1 << code.
`define MMIO_SIZE_B1            3'd0
`define MMIO_SIZE_B2            3'd1
`define MMIO_SIZE_B4            3'd2
`define MMIO_SIZE_B8            3'd3

`endif

//--- mmio_pkg.sv
`include "mmio_config.svh"

package mmio_pkg;

    // Cache geometry, derived from the line count.
    localparam int DC_IDX_W = $clog2(`MMIO_DCACHE_LINES);
    localparam int DC_TAG_W = 64 - DC_IDX_W - 3;   // 3 bits of byte offset.

    // Request from the load/store unit.
    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [7:0]  mask;                         // Byte lanes.
        logic [2:0]  size;                         // Log2 of the byte count.
        logic        we;
        logic        re;
    } core_req_t;

    typedef struct packed {
        logic [63:0] rdata;
        logic        finish;                       // One cycle per request.
    } core_rsp_t;

    // Wishbone classic master side.
    typedef struct packed {
        logic [63:0] adr;
        logic [63:0] dat_w;
        logic [7:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    typedef struct packed {
        logic [63:0] dat_r;
        logic        ack;
    } wb_rsp_t;

    // One address word, seen by the cache or by a device.
    typedef union packed {
        struct packed {
            logic [DC_TAG_W-1:0] tag;
            logic [DC_IDX_W-1:0] index;
            logic [2:0]          offset;
        } cache;
        struct packed {
            logic [47:0] page;
            logic [15:0] reg_off;
        } dev;
    } addr_view_u;

endpackage

//--- mmio_subsys_top.sv
`timescale 1ns/1ns

module mmio_subsys_top (
    input  logic                clk,
    input  logic                rst,
    input  mmio_pkg::core_req_t core_req,
    input  logic                fence,
    output mmio_pkg::core_rsp_t core_rsp,
    output mmio_pkg::wb_req_t   wb_out,
    input  mmio_pkg::wb_rsp_t   wb_in,
    output logic                timer_irq
);

    // Control to cache.
    mmio_pkg::core_req_t cache_req;
    logic                cache_fence;
    mmio_pkg::core_rsp_t cache_rsp;
    // Arbiter ports.
    mmio_pkg::wb_req_t   m0_req, m1_req;
    mmio_pkg::wb_rsp_t   m0_rsp, m1_rsp;
    // Control to timer.
    mmio_pkg::core_req_t timer_req;
    mmio_pkg::core_rsp_t timer_rsp;

    uncache_mmio uncache_mmio_i (
        .clk         (clk),
        .rst         (rst),
        .core_req    (core_req),
        .fence       (fence),
        .core_rsp    (core_rsp),
        .cache_req   (cache_req),
        .cache_fence (cache_fence),
        .cache_rsp   (cache_rsp),
        .bus_req     (m0_req),
        .bus_rsp     (m0_rsp),
        .timer_req   (timer_req),
        .timer_rsp   (timer_rsp)
    );

    dcache_store dcache_store_i (
        .clk     (clk),
        .rst     (rst),
        .req     (cache_req),
        .fence   (cache_fence),
        .rsp     (cache_rsp),
        .bus_req (m1_req),
        .bus_rsp (m1_rsp)
    );

    bus_arbiter bus_arbiter_i (
        .clk    (clk),
        .rst    (rst),
        .m0_req (m0_req),
        .m1_req (m1_req),
        .m0_rsp (m0_rsp),
        .m1_rsp (m1_rsp),
        .wb_out (wb_out),
        .wb_in  (wb_in)
    );

    clint_timer clint_timer_i (
        .clk       (clk),
        .rst       (rst),
        .req       (timer_req),
        .rsp       (timer_rsp),
        .timer_irq (timer_irq)
    );

endmodule

//--- sources.f
+incdir+.
mmio_pkg.sv
clint_timer.sv
bus_arbiter.sv
dcache_store.sv
uncache_mmio.sv
mmio_subsys_top.sv
tb_mmio_subsys.sv

//--- tb_mmio_subsys.sv
`timescale 1ns/1ns
`include "mmio_config.svh"

module tb_mmio_subsys;

    localparam logic [63:0] MEM_BASE = 64'h0000_0000_8000_0000;  // Slave memory of 256 words.
    localparam logic [63:0] DEV_XOR  = 64'h5A5A_5A5A_5A5A_5A5A;  // Device read rule.
    localparam int          WAIT_MAX = 200;                      // Cycles per wait.

    logic                clk;
    logic                rst;
    mmio_pkg::core_req_t core_req;
    logic                fence;
    mmio_pkg::core_rsp_t core_rsp;
    mmio_pkg::wb_req_t   wb_out;
    mmio_pkg::wb_rsp_t   wb_in;
    logic                timer_irq;

    logic [31:0] rng_state = 32'hbb46900f;
    logic [63:0] slv_mem [256];   // Memory behind the bus slave.
    logic [63:0] ref_mem [256];   // Reference model of the same words.
    logic [63:0] log_adr [$];     // One entry per bus transaction.
    logic        log_we  [$];
    logic [7:0]  log_sel [$];
    logic [63:0] log_dat [$];
    int          finish_cnt;
    int          req_cnt;
    int          stb_err_cnt;
    int          test_errs;
    int          tests_ok;
    int          tests_bad;

    mmio_subsys_top mmio_subsys_top_i (
        .clk       (clk),
        .rst       (rst),
        .core_req  (core_req),
        .fence     (fence),
        .core_rsp  (core_rsp),
        .wb_out    (wb_out),
        .wb_in     (wb_in),
        .timer_irq (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                                   // 100 MHz.
    end

    // ######################################################################
    // Helpers and reference rules.
    // ######################################################################
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;   // LCG step.
        return rng_state;
    endfunction

    function automatic logic [63:0] align_down(input logic [63:0] addr, input logic [2:0] size);
        return addr & ~((64'd1 << size) - 64'd1);
    endfunction

    // Byte lanes of an aligned access.
    function automatic logic [7:0] lane_mask(input logic [63:0] addr, input logic [2:0] size);
        logic [7:0] ones;
        case (size)
            3'd0:    ones = 8'h01;
            3'd1:    ones = 8'h03;
            3'd2:    ones = 8'h0F;
            default: ones = 8'hFF;
        endcase
        return ones << addr[2:0];
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] wdata,
                                                input logic [7:0] mask);
        logic [63:0] res;
        for (int b = 0; b < 8; b++) begin
            res[8*b +: 8] = mask[b] ? wdata[8*b +: 8] : old[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic is_memory(input logic [63:0] adr);
        return (adr >= MEM_BASE) && (adr < MEM_BASE + 64'd2048);
    endfunction

    function automatic logic [63:0] slave_data(input logic [63:0] adr);
        if (is_memory(adr)) return slv_mem[adr[10:3]];
        if ((adr >= `MMIO_UART_START && adr <= `MMIO_UART_END)
            || (adr >= `MMIO_SPICTRL_START && adr <= `MMIO_SPICTRL_END)
            || (adr >= `MMIO_SPI_START && adr <= `MMIO_SPI_END)) return adr ^ DEV_XOR;
        return 64'd0;                                            // Unmapped.
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("FAILED %s expected %h actual %h", name, exp, act);
        test_errs++;
    endtask

    task automatic flag_error(input string what);
        $display("ERROR %s", what);
        test_errs++;
    endtask

    task automatic close_test(input string name);
        if (test_errs == 0) begin
            tests_ok++;
            $display("PASS %s", name);
        end else begin
            tests_bad++;
            $display("FAIL %s with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // One core request held until finish and then dropped.
    task automatic access(input logic is_we, input logic [63:0] addr, input logic [63:0] wdata,
                          input logic [2:0] size, output logic [63:0] rdata);
        int waited;
        @(posedge clk);
        core_req.addr  <= addr;
        core_req.wdata <= wdata;
        core_req.mask  <= lane_mask(align_down(addr, size), size);
        core_req.size  <= size;
        core_req.we    <= is_we;
        core_req.re    <= !is_we;
        req_cnt++;
        waited = 0;
        @(negedge clk);
        while (!core_rsp.finish && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (!core_rsp.finish) begin
            flag_error($sformatf("no finish within %0d cycles for address %h",
                                 WAIT_MAX, addr));
        end
        rdata = core_rsp.rdata;                                  // Valid with finish.
        @(posedge clk);
        core_req <= '0;
    endtask

    task automatic pulse_fence();
        @(posedge clk);
        fence <= 1'b1;
        @(posedge clk);
        fence <= 1'b0;
    endtask

    // ######################################################################
    // Wishbone slave model and bus monitor.
    // ######################################################################
    initial begin : wb_slave
        mmio_pkg::wb_req_t seen;
        int                delay;
        wb_in = '0;
        forever begin
            @(negedge clk);
            if (!rst && wb_out.cyc && wb_out.stb) begin
                delay = (next_rand() >> 20) % 4;                 // 0 to 3 wait cycles.
                repeat (delay) @(negedge clk);
                seen = wb_out;
                log_adr.push_back(seen.adr);
                log_we.push_back(seen.we);
                log_sel.push_back(seen.sel);
                log_dat.push_back(seen.dat_w);
                @(posedge clk);
                wb_in.ack   <= 1'b1;
                wb_in.dat_r <= seen.we ? 64'd0 : slave_data(seen.adr);
                if (seen.we && is_memory(seen.adr)) begin
                    slv_mem[seen.adr[10:3]] <= merge_bytes(slv_mem[seen.adr[10:3]],
                                                           seen.dat_w, seen.sel);
                end
                @(posedge clk);
                wb_in.ack <= 1'b0;                               // One-cycle ack.
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (core_rsp.finish) finish_cnt++;
            if (wb_out.stb && !wb_out.cyc) stb_err_cnt++;
        end
    end

    // ######################################################################
    // Test sequence.
    // ######################################################################
    initial begin : main
        logic [63:0] addr, hot_addr, wdata, rdata, t0, t1;
        logic [31:0] rnd;
        logic [2:0]  size;
        logic        is_we;
        int          nlog;
        int          waited;
        rst         = 1'b1;
        fence       = 1'b0;
        core_req    = '0;
        finish_cnt  = 0;
        req_cnt     = 0;
        stb_err_cnt = 0;
        test_errs   = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        for (int i = 0; i < 256; i++) begin
            addr       = MEM_BASE + 64'(i) * 64'd8;
            slv_mem[i] = {~addr[31:0], addr[31:0]};             // Pattern over the address.
            ref_mem[i] = {~addr[31:0], addr[31:0]};
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        if (wb_out.cyc || wb_out.stb) flag_error("bus cycle active after reset");
        if (core_rsp.finish) flag_error("finish high after reset");
        if (timer_irq) flag_error("timer_irq high after reset");
        close_test("reset_state");

        // Random cacheable loads and stores.
        for (int n = 0; n < 300; n++) begin
            rnd   = next_rand();
            size  = {1'b0, rnd[31:30]};
            is_we = rnd[16];
            addr  = align_down(MEM_BASE + ((next_rand() >> 12) & 32'h1FF), size);
            wdata = {next_rand(), next_rand()};
            nlog  = log_adr.size();
            access(is_we, addr, wdata, size, rdata);
            if (is_we) begin
                if (log_adr.size() != nlog + 1) begin
                    flag_error("store did not give exactly one bus write");
                end else begin
                    if (!log_we[nlog]) flag_error("store logged as a bus read");
                    if (log_sel[nlog] !== lane_mask(addr, size))
                        report_mismatch("cacheable_rw sel", lane_mask(addr, size), log_sel[nlog]);
                    if (log_dat[nlog] !== wdata)
                        report_mismatch("cacheable_rw wdata", wdata, log_dat[nlog]);
                end
                ref_mem[addr[10:3]] = merge_bytes(ref_mem[addr[10:3]], wdata,
                                                  lane_mask(addr, size));
            end else begin
                if (rdata !== ref_mem[addr[10:3]])
                    report_mismatch("cacheable_rw", ref_mem[addr[10:3]], rdata);
            end
        end
        close_test("cacheable_rw");

        // Miss then hit on a clean cache.
        pulse_fence();
        hot_addr = MEM_BASE + ((next_rand() >> 12) & 32'h7F8);
        nlog     = log_adr.size();
        access(1'b0, hot_addr, 64'd0, 3'd3, rdata);
        if (log_adr.size() != nlog + 1) begin
            flag_error("first read did not give exactly one bus read");
        end else begin
            if (log_we[nlog]) flag_error("refill logged as a bus write");
            if (log_adr[nlog] !== hot_addr) report_mismatch("hit_miss refill", hot_addr,
                                                            log_adr[nlog]);
        end
        if (rdata !== ref_mem[hot_addr[10:3]])
            report_mismatch("hit_miss", ref_mem[hot_addr[10:3]], rdata);
        nlog = log_adr.size();
        access(1'b0, hot_addr, 64'd0, 3'd3, rdata);
        if (log_adr.size() != nlog) flag_error("second read of a cached word went to the bus");
        if (rdata !== ref_mem[hot_addr[10:3]])
            report_mismatch("hit_miss", ref_mem[hot_addr[10:3]], rdata);
        close_test("hit_miss");

        pulse_fence();                                           // Drops every line.
        nlog = log_adr.size();
        access(1'b0, hot_addr, 64'd0, 3'd3, rdata);
        if (log_adr.size() != nlog + 1) flag_error("read after fence did not refill");
        if (rdata !== ref_mem[hot_addr[10:3]])
            report_mismatch("fence", ref_mem[hot_addr[10:3]], rdata);
        close_test("fence");

        // Uncached device windows.
        for (int n = 0; n < 40; n++) begin
            rnd   = next_rand();
            size  = {1'b0, rnd[31:30]};
            is_we = rnd[16];
            wdata = {next_rand(), next_rand()};
            case ((next_rand() >> 24) % 3)
                0:       addr = `MMIO_UART_START + ((next_rand() >> 8) & 32'hFFF);
                1:       addr = `MMIO_SPICTRL_START + ((next_rand() >> 8) & 32'hFFF);
                default: addr = `MMIO_SPI_START + ((next_rand() >> 4) & 32'h0FFF_FFFF);
            endcase
            nlog = log_adr.size();
            access(is_we, addr, wdata, size, rdata);
            if (log_adr.size() != nlog + 1) begin
                flag_error("device access did not give exactly one bus cycle");
            end else begin
                if (log_adr[nlog] !== align_down(addr, size))
                    report_mismatch("device addr", align_down(addr, size), log_adr[nlog]);
                if (log_we[nlog] !== is_we) flag_error("device cycle has the wrong direction");
                if (log_sel[nlog] !== lane_mask(align_down(addr, size), size))
                    report_mismatch("device sel", lane_mask(align_down(addr, size), size),
                                    log_sel[nlog]);
                if (is_we && log_dat[nlog] !== wdata)
                    report_mismatch("device wdata", wdata, log_dat[nlog]);
            end
            if (!is_we && rdata !== (align_down(addr, size) ^ DEV_XOR))
                report_mismatch("device read", align_down(addr, size) ^ DEV_XOR, rdata);
        end
        nlog = log_adr.size();
        access(1'b0, hot_addr, 64'd0, 3'd3, rdata);              // Still cached.
        if (log_adr.size() != nlog) flag_error("device traffic disturbed the cache");
        if (rdata !== ref_mem[hot_addr[10:3]])
            report_mismatch("device", ref_mem[hot_addr[10:3]], rdata);
        close_test("device");

        // Local timer accesses stay off the bus.
        nlog  = log_adr.size();
        wdata = {32'h8000_0000 | next_rand(), next_rand()};      // Far in the future.
        access(1'b1, `MMIO_CLINT_START + `MMIO_CLINT_MTIMECMP, wdata, 3'd3, rdata);
        access(1'b0, `MMIO_CLINT_START + `MMIO_CLINT_MTIMECMP, 64'd0, 3'd3, rdata);
        if (rdata !== wdata) report_mismatch("clint mtimecmp", wdata, rdata);
        access(1'b0, `MMIO_CLINT_START + `MMIO_CLINT_MTIME, 64'd0, 3'd3, t0);
        access(1'b0, `MMIO_CLINT_START + `MMIO_CLINT_MTIME, 64'd0, 3'd3, t1);
        if (t1 <= t0) flag_error("mtime did not increase between two reads");
        access(1'b1, `MMIO_CLINT_START + `MMIO_CLINT_MTIMECMP, t1 + 64'd40, 3'd3, rdata);
        waited = 0;
        while (!timer_irq && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (!timer_irq) flag_error("timer_irq did not rise after mtimecmp was set");
        access(1'b1, `MMIO_CLINT_START + `MMIO_CLINT_MTIMECMP, '1, 3'd3, rdata);
        waited = 0;
        while (timer_irq && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (timer_irq) flag_error("timer_irq stayed high with mtimecmp at all ones");
        if (log_adr.size() != nlog) flag_error("CLINT access appeared on the bus");
        close_test("clint");

        if (finish_cnt != req_cnt) report_mismatch("handshake finish count", req_cnt, finish_cnt);
        if (stb_err_cnt != 0) flag_error("stb was seen without cyc");
        close_test("handshake");

        $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- uncache_mmio.sv
`timescale 1ns/1ns
`include "mmio_config.svh"

module uncache_mmio (
    input  logic                clk,
    input  logic                rst,
    input  mmio_pkg::core_req_t core_req,
    input  logic                fence,
    output mmio_pkg::core_rsp_t core_rsp,
    output mmio_pkg::core_req_t cache_req,
    output logic                cache_fence,
    input  mmio_pkg::core_rsp_t cache_rsp,
    output mmio_pkg::wb_req_t   bus_req,
    input  mmio_pkg::wb_rsp_t   bus_rsp,
    output mmio_pkg::core_req_t timer_req,
    input  mmio_pkg::core_rsp_t timer_rsp
);

    typedef enum logic [1:0] {S_IDLE, S_ROUTE, S_WAIT, S_DONE} state_t;
    typedef enum logic [1:0] {R_CACHE, R_BUS, R_TIMER} route_t;

    state_t               state_q, state_d;
    route_t               route_q, route_d;
    logic                 req_valid;
    logic                 in_clint, in_dev;
    mmio_pkg::addr_view_u av;
    logic [2:0]           off_aligned;   // Byte offset after size alignment.
    logic [63:0]          rdata_q;       // Captured device read data.
    logic                 bus_active;
    logic                 sub_finish;

    assign req_valid = core_req.we || core_req.re;

    // ######################################################################
    // Window decode.
    // ######################################################################
    assign in_clint = (core_req.addr >= `MMIO_CLINT_START) && (core_req.addr <= `MMIO_CLINT_END);
    assign in_dev   = ((core_req.addr >= `MMIO_UART_START) && (core_req.addr <= `MMIO_UART_END))
                   || ((core_req.addr >= `MMIO_SPICTRL_START)
                       && (core_req.addr <= `MMIO_SPICTRL_END))
                   || ((core_req.addr >= `MMIO_SPI_START) && (core_req.addr <= `MMIO_SPI_END));
    assign route_d  = in_clint ? R_TIMER : (in_dev ? R_BUS : R_CACHE);   // Else cacheable.

    // Align the device address down to the access size.
    assign av = core_req.addr;
    always_comb begin
        case (core_req.size)
            `MMIO_SIZE_B1: off_aligned = av.cache.offset;
            `MMIO_SIZE_B2: off_aligned = {av.cache.offset[2:1], 1'b0};
            `MMIO_SIZE_B4: off_aligned = {av.cache.offset[2], 2'b00};
            default:       off_aligned = 3'b000;               // Doubleword.
        endcase
    end

    // ######################################################################
    // Request FSM.
    // ######################################################################
    assign sub_finish = (route_q == R_CACHE) ? cache_rsp.finish : timer_rsp.finish;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:  if (req_valid) state_d = S_ROUTE;      // Route latched here.
            S_ROUTE: state_d = S_WAIT;                      // Command issued.
            S_WAIT: begin
                if (route_q == R_BUS) begin
                    if (bus_rsp.ack) state_d = S_DONE;      // Finish follows the ack.
                end else if (sub_finish) begin
                    state_d = S_DONE;
                end
            end
            default: state_d = S_IDLE;                      // Core drops its request.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            route_q <= R_CACHE;
        end else begin
            state_q <= state_d;
            if (state_q == S_IDLE) route_q <= route_d;      // Decode once per request.
        end
    end

    always_ff @(posedge clk) begin
        if (bus_active && bus_rsp.ack) rdata_q <= bus_rsp.dat_r;
    end

    // Cache and timer see a one-cycle command.
    assign cache_req   = (state_q == S_ROUTE && route_q == R_CACHE) ? core_req : '0;
    assign timer_req   = (state_q == S_ROUTE && route_q == R_TIMER) ? core_req : '0;
    assign cache_fence = fence && !req_valid && (state_q == S_IDLE);

    // Device access on arbiter port 0.
    assign bus_active    = (state_q == S_WAIT) && (route_q == R_BUS);
    assign bus_req.adr   = {av.cache.tag, av.cache.index, off_aligned};
    assign bus_req.dat_w = core_req.wdata;
    assign bus_req.sel   = core_req.mask;
    assign bus_req.we    = core_req.we;
    assign bus_req.cyc   = bus_active;
    assign bus_req.stb   = bus_active;

    always_comb begin
        core_rsp.finish = ((state_q == S_WAIT) && (route_q != R_BUS) && sub_finish)
                       || ((state_q == S_DONE) && (route_q == R_BUS));
        case (route_q)
            R_BUS:   core_rsp.rdata = rdata_q;
            R_TIMER: core_rsp.rdata = timer_rsp.rdata;
            default: core_rsp.rdata = cache_rsp.rdata;
        endcase
    end

    // A finish answers a held request and lasts one cycle.
    a_finish_held: assert property (@(posedge clk) disable iff (rst)
        core_rsp.finish |-> req_valid ##1 !core_rsp.finish);

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
        bus_req.stb |-> bus_req.cyc);

    // The strobed cycle holds its address until the ack.
    a_bus_hold: assert property (@(posedge clk) disable iff (rst)
        (bus_req.stb && !bus_rsp.ack) |=> bus_req.stb && $stable(bus_req.adr));

endmodule
